//--- ccp_tag_pipe.f
+incdir+verification
verilog/ccp_pkg.sv
verilog/ccp_index_stage.sv
verilog/ccp_tag_array.sv
verilog/ccp_lookup_stage.sv
verilog/ccp_maint_apb.sv
verilog/ccp_tag_pipe.sv
verification/ccp_tag_pipe_tb.sv

//--- verification/ccp_tag_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the tag array for the tag pipeline testbench.
// Included inside the testbench module after the package import.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CCP_TAG_MODEL_SVH
`define CCP_TAG_MODEL_SVH

tag_entry_t model_sets [N_SETS][N_WAYS];

function automatic void model_reset();
   for (int s = 0; s < N_SETS; s++) begin
      for (int w = 0; w < N_WAYS; w++) begin
         model_sets[s][w] = '0;
      end
   end
endfunction

function automatic int model_hit_way(input int s, input logic [TAG_W-1:0] t);
   for (int w = 0; w < N_WAYS; w++) begin
      if (model_sets[s][w].state != st_invalid && model_sets[s][w].tag == t) begin
         return w;
      end
   end
   return -1;
endfunction

// True if another way of the set holds this tag in a valid state
function automatic bit model_tag_live(input int s, input int skip_way,
                                      input logic [TAG_W-1:0] t);
   for (int w = 0; w < N_WAYS; w++) begin
      if (w != skip_way && model_sets[s][w].state != st_invalid
          && model_sets[s][w].tag == t) begin
         return 1'b1;
      end
   end
   return 1'b0;
endfunction

// Lowest empty way first, then the lowest way not recently used
function automatic int model_victim(input int s);
   for (int w = 0; w < N_WAYS; w++) begin
      if (model_sets[s][w].state == st_invalid) begin
         return w;
      end
   end
   for (int w = 0; w < N_WAYS; w++) begin
      if (!model_sets[s][w].nru) begin
         return w;
      end
   end
   // Every nru bit set by maintenance, way 0
   return 0;
endfunction

function automatic void model_touch(input int s, input int w);
   int used;
   used = 0;
   model_sets[s][w].nru = 1'b1;
   for (int i = 0; i < N_WAYS; i++) begin
      if (model_sets[s][i].nru) begin
         used++;
      end
   end
   if (used == N_WAYS) begin
      for (int i = 0; i < N_WAYS; i++) begin
         if (i != w) begin
            model_sets[s][i].nru = 1'b0;
         end
      end
   end
endfunction

// Applies one request in order and returns the response it should give
function automatic tag_rsp_t model_request(input tag_req_t r);
   int               s;
   int               hw;
   int               vw;
   logic [TAG_W-1:0] t;
   tag_rsp_t         e;
   s  = int'((r.address >> LINE_OFFSET_W) % N_SETS);
   t  = TAG_W'(r.address >> (LINE_OFFSET_W + SET_W));
   hw = model_hit_way(s, t);
   e  = '0;
   e.security = r.security;
   e.hit      = (hw >= 0);
   if (hw >= 0) begin
      e.way       = WAY_W'(hw);
      e.old_state = model_sets[s][hw].state;
      if (r.opcode != op_lookup) begin
         model_sets[s][hw].state = r.new_state;
         model_touch(s, hw);
      end
   end else if (r.opcode == op_allocate) begin
      vw          = model_victim(s);
      e.way       = WAY_W'(vw);
      e.old_state = model_sets[s][vw].state;
      if (model_sets[s][vw].state != st_invalid) begin
         e.evict_valid = 1'b1;
         e.evict_tag   = model_sets[s][vw].tag;
         e.evict_state = model_sets[s][vw].state;
      end
      model_sets[s][vw].tag   = t;
      model_sets[s][vw].state = r.new_state;
      model_touch(s, vw);
   end else begin
      e.way       = '0;
      e.old_state = model_sets[s][0].state;
   end
   return e;
endfunction

// APB entry access: paddr[11:10] action, [7:6] way, [5:2] set
function automatic void model_maint(input logic wr, input logic [11:0] addr,
                                    input logic [31:0] wdata,
                                    output logic err, output logic [31:0] rdata);
   int         s;
   int         w;
   tag_entry_t e;
   s     = addr[5:2];
   w     = addr[7:6];
   e     = model_sets[s][w];
   err   = 1'b0;
   rdata = '0;
   if (!wr) begin
      if (addr[11:10] != 2'b00) begin
         err = 1'b1;
      end else begin
         rdata = {7'd0, e.nru, e.state, e.tag};
      end
   end else if (maint_action_e'(addr[11:10]) == maint_write) begin
      e.tag   = wdata[21:0];
      e.state = cache_state_e'(wdata[23:22]);
      e.nru   = wdata[24];
      model_sets[s][w] = e;
   end else if (maint_action_e'(addr[11:10]) == maint_recall) begin
      model_sets[s][w].state = st_invalid;
   end else begin
      err = 1'b1;
   end
endfunction

`endif

//--- verification/ccp_tag_pipe_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the tag pipeline with directed and random requests
// mixed with APB maintenance, checked against a tag array model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module ccp_tag_pipe_tb;
   import ccp_pkg::*;

   localparam int N_REQ       = 3000;
   localparam int N_APB       = 200;
   localparam int N_SWEEP     = 16;
   localparam int CYCLE_LIMIT = 4 * N_REQ + 12 * N_APB + 600;

   logic        clk;
   logic        reset_n;
   logic        req_valid;
   logic        req_ready;
   tag_req_t    req;
   logic        rsp_valid;
   tag_rsp_t    rsp;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [11:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   integer      seed;
   int unsigned cycle;
   int          value_errors;
   int          protocol_errors;
   int          req_count;
   int          rsp_count;
   int          apb_count;
   tag_rsp_t    exp_q[$];
   int unsigned due_q[$];

   `include "ccp_tag_model.svh"

   ccp_tag_pipe i_ccp_tag_pipe (
      .clk       (clk),
      .reset_n   (reset_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   task automatic compare_field(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         value_errors++;
         $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   // Four sets and eight tags per set keep hits and evictions frequent
   function automatic logic [SET_W-1:0] pool_set(input int k);
      case (k)
         0:       return 4'd1;
         1:       return 4'd6;
         2:       return 4'd11;
         default: return 4'd15;
      endcase
   endfunction

   function automatic logic [TAG_W-1:0] pool_tag(input int k);
      return TAG_W'(32'h0a5c0 + k * 307);
   endfunction

   function automatic tag_req_t make_req(input req_opcode_e op, input int set_k,
                                         input int tag_k, input cache_state_e st);
      tag_req_t r;
      r.address   = {pool_tag(tag_k), pool_set(set_k), LINE_OFFSET_W'($random(seed))};
      r.security  = 1'($random(seed));
      r.opcode    = op;
      r.new_state = st;
      return r;
   endfunction

   // Ready and valid are settled by the falling edge before the accepting edge
   task automatic send_request(input tag_req_t r);
      bit accepted;
      accepted = 1'b0;
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= r;
      while (!accepted) begin
         @(negedge clk);
         if (req_ready) begin
            accepted = 1'b1;
            exp_q.push_back(model_request(r));
            due_q.push_back(cycle + 3);
            req_count++;
         end else begin
            @(posedge clk);
         end
      end
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      req_valid <= 1'b0;
   endtask

   task automatic random_request();
      int           k;
      req_opcode_e  op;
      cache_state_e st;
      k  = {$random(seed)} % 20;
      op = (k < 6) ? op_lookup : (k < 15) ? op_allocate : op_update;
      st = (({$random(seed)} % 8) == 0) ? st_invalid
                                         : cache_state_e'(1 + {$random(seed)} % 3);
      send_request(make_req(op, {$random(seed)} % 4, {$random(seed)} % 8, st));
   endtask

   task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                               input logic [31:0] wdata);
      logic        exp_err;
      logic [31:0] exp_rdata;
      model_maint(wr, addr, wdata, exp_err, exp_rdata);
      @(posedge clk);
      req_valid <= 1'b0;
      psel      <= 1'b1;
      penable   <= 1'b0;
      pwrite    <= wr;
      paddr     <= addr;
      pwdata    <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      while (!pready) begin
         compare_field("req_ready", req_ready, 1'b0);
         @(negedge clk);
      end
      compare_field("req_ready", req_ready, 1'b0);
      compare_field("pslverr", pslverr, exp_err);
      if (!wr) begin
         compare_field("prdata", prdata, exp_rdata);
      end
      apb_count++;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic random_maint();
      int               k;
      logic [SET_W-1:0] s;
      logic [WAY_W-1:0] w;
      logic [TAG_W-1:0] t;
      logic [1:0]       act;
      logic [31:0]      wdata;
      cache_state_e     st;
      k  = {$random(seed)} % 10;
      s  = pool_set({$random(seed)} % 4);
      w  = WAY_W'({$random(seed)} % 4);
      t  = pool_tag({$random(seed)} % 8);
      st = cache_state_e'({$random(seed)} % 4);
      // A second valid copy of a tag in one set is not a legal state
      if (model_tag_live(s, w, t)) begin
         st = st_invalid;
      end
      wdata        = $random(seed);
      wdata[21:0]  = t;
      wdata[23:22] = st;
      wdata[24]    = 1'($random(seed));
      act = 2'd0;
      if (k == 4) begin
         act = 2'd1 + 2'({$random(seed)} % 3);
      end else if (k == 7 || k == 8) begin
         act = 2'd1;
      end else if (k == 9) begin
         act = 2'd2 + 2'({$random(seed)} % 2);
      end
      apb_transfer(k >= 5, {act, 2'($random(seed)), w, s, 2'b00}, wdata);
   endtask

   always @(negedge clk) begin : response_check
      tag_rsp_t    exp;
      int unsigned due;
      if (reset_n) begin
         if (rsp_valid) begin
            assert (exp_q.size() != 0) else begin
               protocol_errors++;
               $display("[ERROR] %0t response came with no request outstanding", $time);
            end
            if (exp_q.size() != 0) begin
               exp = exp_q.pop_front();
               due = due_q.pop_front();
               rsp_count++;
               compare_field("rsp_valid cycle", cycle, due);
               compare_field("rsp.hit", rsp.hit, exp.hit);
               compare_field("rsp.way", rsp.way, exp.way);
               compare_field("rsp.old_state", rsp.old_state, exp.old_state);
               compare_field("rsp.security", rsp.security, exp.security);
               compare_field("rsp.evict_valid", rsp.evict_valid, exp.evict_valid);
               compare_field("rsp.evict_tag", rsp.evict_tag, exp.evict_tag);
               compare_field("rsp.evict_state", rsp.evict_state, exp.evict_state);
            end
         end
         if (due_q.size() != 0) begin
            assert (due_q[0] >= cycle) else begin
               protocol_errors++;
               $display("[ERROR] %0t a response did not arrive when due", $time);
               void'(exp_q.pop_front());
               void'(due_q.pop_front());
            end
         end
      end
   end

   initial begin : watchdog
      wait (cycle >= CYCLE_LIMIT);
      $display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
   end

   initial begin : main
      int s_k;
      int w_k;
      seed            = 32'h0c15074b;
      clk             = 1'b0;
      reset_n         = 1'b0;
      req_valid       = 1'b0;
      req             = '0;
      psel            = 1'b0;
      penable         = 1'b0;
      pwrite          = 1'b0;
      paddr           = '0;
      pwdata          = '0;
      cycle           = 0;
      value_errors    = 0;
      protocol_errors = 0;
      req_count       = 0;
      rsp_count       = 0;
      apb_count       = 0;
      model_reset();
      repeat (4) @(posedge clk);
      reset_n <= 1'b1;
      @(negedge clk);
      compare_field("rsp_valid", rsp_valid, 1'b0);
      compare_field("pready", pready, 1'b0);
      compare_field("pslverr", pslverr, 1'b0);
      compare_field("req_ready", req_ready, 1'b1);

      // Cold miss, then fill one set and force an NRU eviction
      send_request(make_req(op_lookup, 0, 0, st_invalid));
      for (int k = 0; k < 5; k++) begin
         send_request(make_req(op_allocate, 1, k, cache_state_e'(1 + k % 3)));
      end
      send_request(make_req(op_lookup, 1, 4, st_invalid));
      send_request(make_req(op_lookup, 1, 0, st_invalid));
      send_request(make_req(op_update, 1, 6, st_owned));
      send_request(make_req(op_update, 1, 4, st_unique));
      send_request(make_req(op_lookup, 1, 4, st_invalid));
      idle_cycle();

      while (req_count < N_REQ) begin
         if ((req_count % 16) == 0 && apb_count < N_APB - N_SWEEP) begin
            random_maint();
         end
         if (({$random(seed)} % 4) == 0) begin
            idle_cycle();
         end
         random_request();
      end
      idle_cycle();
      while (apb_count < N_APB - N_SWEEP) begin
         random_maint();
      end

      // Read back every entry of the sets in use
      for (s_k = 0; s_k < 4; s_k++) begin
         for (w_k = 0; w_k < N_WAYS; w_k++) begin
            apb_transfer(1'b0, {4'b0000, WAY_W'(w_k), pool_set(s_k), 2'b00}, 32'h0);
         end
      end

      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      repeat (3) @(negedge clk);
      $display("Summary: %0d req, %0d rsp, %0d apb, %0d value errors, %0d protocol errors",
               req_count, rsp_count, apb_count, value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/ccp_index_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage p0 of the tag pipeline: accepts a request, splits the
// address into set and tag and launches the tag array read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module ccp_index_stage (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       req_valid,
   input  ccp_pkg::tag_req_t          req,
   input  logic                       maint_busy,
   output logic                       req_ready,
   output logic                       rd_en,
   output logic [ccp_pkg::SET_W-1:0]  rd_set,
   output logic                       p1_valid,
   output ccp_pkg::tag_req_t          p1_req,
   output logic [ccp_pkg::TAG_W-1:0]  p1_tag,
   output logic [ccp_pkg::SET_W-1:0]  p1_set
);
   import ccp_pkg::*;

   logic              accept;
   logic [SET_W-1:0]  req_set;
   logic [TAG_W-1:0]  req_tag;

   // Only maintenance holds requests off
   assign req_ready = !maint_busy;
   assign accept    = req_valid && req_ready;

   assign req_set = req.address[LINE_OFFSET_W +: SET_W];
   assign req_tag = req.address[ADDRESS_W-1 -: TAG_W];

   // Array read goes out with the accept, data lines up with p1
   assign rd_en  = accept;
   assign rd_set = req_set;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         p1_valid <= 1'b0;
      end else begin
         p1_valid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         p1_req <= req;
         p1_tag <= req_tag;
         p1_set <= req_set;
      end
   end

   // Requester must hold a stalled request
   req_stable_while_stalled: assert property (
      @(posedge clk) disable iff (!reset_n)
      (req_valid && !req_ready) ##1 req_valid |-> $stable(req)
   );

endmodule

`default_nettype wire

//--- verilog/ccp_lookup_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stages p1 and p2: hit compare, victim choice, NRU and state
// writeback, then the response two edges after acceptance.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module ccp_lookup_stage (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       p1_valid,
   input  ccp_pkg::tag_req_t          p1_req,
   input  logic [ccp_pkg::TAG_W-1:0]  p1_tag,
   input  logic [ccp_pkg::SET_W-1:0]  p1_set,
   input  ccp_pkg::tag_set_t          rd_data,
   output logic                       wr_en,
   output logic [ccp_pkg::SET_W-1:0]  wr_set,
   output ccp_pkg::tag_set_t          wr_data,
   output logic                       rsp_valid,
   output ccp_pkg::tag_rsp_t          rsp,
   output logic                       pipe_empty
);
   import ccp_pkg::*;

   logic               fwd_valid;
   logic [SET_W-1:0]   fwd_set;
   tag_set_t           fwd_data;
   tag_set_t           cur_set;
   tag_set_t           nxt_set;
   logic [N_WAYS-1:0]  hit_vec;
   logic [N_WAYS-1:0]  inv_vec;
   logic [N_WAYS-1:0]  nru_clr_vec;
   logic               hit;
   logic [WAY_W-1:0]   hit_way;
   logic [WAY_W-1:0]   victim_way;
   logic [WAY_W-1:0]   rsp_way;
   logic               do_write;
   logic               evict;
   tag_rsp_t           p1_rsp;
   logic               p2_valid;
   tag_rsp_t           p2_rsp;

   // Mark a way used; once every way is marked keep only this one
   function automatic tag_set_t nru_touch(tag_set_t s, logic [WAY_W-1:0] w);
      tag_set_t t;
      logic     all_used;
      t = s;
      t.way[w].nru = 1'b1;
      all_used = 1'b1;
      for (int i = 0; i < N_WAYS; i++) begin
         all_used = all_used && t.way[i].nru;
      end
      if (all_used) begin
         for (int i = 0; i < N_WAYS; i++) begin
            t.way[i].nru = (i == w);
         end
      end
      return t;
   endfunction

   // Read missed the write made on the same edge
   assign cur_set = (fwd_valid && (fwd_set == p1_set)) ? fwd_data : rd_data;

   always_comb begin
      for (int i = 0; i < N_WAYS; i++) begin
         inv_vec[i]     = (cur_set.way[i].state == st_invalid);
         hit_vec[i]     = !inv_vec[i] && (cur_set.way[i].tag == p1_tag);
         nru_clr_vec[i] = !cur_set.way[i].nru;
      end
   end

   assign hit = |hit_vec;

   // Downward scans so the lowest way wins; invalid ways beat NRU
   always_comb begin
      hit_way    = '0;
      victim_way = '0;
      for (int i = N_WAYS-1; i >= 0; i--) begin
         if (hit_vec[i]) begin
            hit_way = WAY_W'(i);
         end
      end
      for (int i = N_WAYS-1; i >= 0; i--) begin
         if (nru_clr_vec[i]) begin
            victim_way = WAY_W'(i);
         end
      end
      for (int i = N_WAYS-1; i >= 0; i--) begin
         if (inv_vec[i]) begin
            victim_way = WAY_W'(i);
         end
      end
   end

   always_comb begin
      nxt_set  = cur_set;
      do_write = 1'b0;
      evict    = 1'b0;
      rsp_way  = '0;
      if (hit) begin
         rsp_way = hit_way;
      end else if (p1_req.opcode == op_allocate) begin
         rsp_way = victim_way;
      end
      if (hit && (p1_req.opcode == op_update || p1_req.opcode == op_allocate)) begin
         nxt_set.way[hit_way].state = p1_req.new_state;
         nxt_set  = nru_touch(nxt_set, hit_way);
         do_write = 1'b1;
      end else if (!hit && p1_req.opcode == op_allocate) begin
         evict = !inv_vec[victim_way];
         nxt_set.way[victim_way].tag   = p1_tag;
         nxt_set.way[victim_way].state = p1_req.new_state;
         nxt_set  = nru_touch(nxt_set, victim_way);
         do_write = 1'b1;
      end
   end

   always_comb begin
      p1_rsp             = '0;
      p1_rsp.hit         = hit;
      p1_rsp.way         = rsp_way;
      p1_rsp.old_state   = cur_set.way[rsp_way].state;
      p1_rsp.security    = p1_req.security;
      p1_rsp.evict_valid = evict;
      if (evict) begin
         p1_rsp.evict_tag   = cur_set.way[victim_way].tag;
         p1_rsp.evict_state = cur_set.way[victim_way].state;
      end
   end

   // Writeback lands at the p1 to p2 edge
   assign wr_en   = p1_valid && do_write;
   assign wr_set  = p1_set;
   assign wr_data = nxt_set;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         fwd_valid <= 1'b0;
         p2_valid  <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         fwd_valid <= wr_en;
         p2_valid  <= p1_valid;
         rsp_valid <= p2_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         fwd_set  <= p1_set;
         fwd_data <= nxt_set;
      end
      if (p1_valid) begin
         p2_rsp <= p1_rsp;
      end
      if (p2_valid) begin
         rsp <= p2_rsp;
      end
   end

   assign pipe_empty = !p1_valid && !p2_valid;

   // A tag lives in at most one way of its set
   hit_ways_onehot0: assert property (
      @(posedge clk) disable iff (!reset_n)
      p1_valid |-> $onehot0(hit_vec)
   );

endmodule

`default_nettype wire

//--- verilog/ccp_maint_apb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB maintenance port: read, write or recall one tag entry.
// Blocks new requests and waits for the pipeline to drain first.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module ccp_maint_apb (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [11:0]                paddr,
   input  logic [31:0]                pwdata,
   output logic [31:0]                prdata,
   output logic                       pready,
   output logic                       pslverr,
   input  logic                       pipe_empty,
   output logic                       maint_busy,
   output logic                       rd_en,
   output logic [ccp_pkg::SET_W-1:0]  rd_set,
   input  ccp_pkg::tag_set_t          rd_data,
   output logic                       wr_en,
   output logic [ccp_pkg::SET_W-1:0]  wr_set,
   output ccp_pkg::tag_set_t          wr_data
);
   import ccp_pkg::*;

   typedef enum logic [2:0] {
      s_idle,
      s_drain,
      s_read,
      s_write,
      s_done
   } maint_state_e;

   maint_state_e   state;
   maint_state_e   state_nxt;
   maint_action_e  action;
   logic [WAY_W-1:0] way;
   logic           err;
   logic           err_q;
   tag_entry_t     old_entry;
   tag_entry_t     new_entry;
   logic [31:0]    rdata_q;

   // paddr[11:10] action, [7:6] way, [5:2] set
   assign action = maint_action_e'(paddr[11:10]);
   assign way    = paddr[7:6];
   assign rd_set = paddr[5:2];
   assign wr_set = paddr[5:2];

   assign err = pwrite ? !(action == maint_write || action == maint_recall)
                       : (paddr[11:10] != 2'b00);

   assign old_entry = rd_data.way[way];

   always_comb begin
      new_entry = old_entry;
      if (action == maint_recall) begin
         new_entry.state = st_invalid;
      end else begin
         new_entry = tag_entry_t'(pwdata[$bits(tag_entry_t)-1:0]);
      end
   end

   // Other ways go back unchanged
   always_comb begin
      wr_data          = rd_data;
      wr_data.way[way] = new_entry;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         s_idle:  if (psel) state_nxt = s_drain;
         s_drain: if (pipe_empty) state_nxt = s_read;
         s_read:  state_nxt = s_write;
         s_write: state_nxt = s_done;
         default: state_nxt = s_idle;
      endcase
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state <= s_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // Array data from s_read is valid in s_write
   always_ff @(posedge clk) begin
      if (state == s_write) begin
         err_q   <= err;
         rdata_q <= (pwrite || err) ? '0
                    : {{(32-$bits(tag_entry_t)){1'b0}}, old_entry};
      end
   end

   assign rd_en      = (state == s_read);
   assign wr_en      = (state == s_write) && pwrite && !err;
   assign maint_busy = (state != s_idle);
   assign pready     = (state == s_done);
   assign pslverr    = pready && err_q;
   assign prdata     = pready ? rdata_q : '0;

   // Completion only inside the access phase of the master
   pready_in_access_phase: assert property (
      @(posedge clk) disable iff (!reset_n)
      pready |-> (psel && penable)
   );

endmodule

`default_nettype wire

//--- verilog/ccp_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared geometry, encodings and bundles for the cache tag pipeline.
// Modules import this package inside their bodies.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package ccp_pkg;

   // Cache geometry, one tag bank
   localparam int ADDRESS_W     = 32;
   localparam int LINE_OFFSET_W = 6;
   localparam int N_SETS        = 16;
   localparam int SET_W         = 4;
   localparam int N_WAYS        = 4;
   localparam int WAY_W         = 2;
   localparam int TAG_W         = ADDRESS_W - SET_W - LINE_OFFSET_W;

   // Line state, zero means the way is empty
   typedef enum logic [1:0] {
      st_invalid = 2'd0,
      st_shared  = 2'd1,
      st_owned   = 2'd2,
      st_unique  = 2'd3
   } cache_state_e;

   typedef enum logic [1:0] {
      op_lookup   = 2'd0,
      op_allocate = 2'd1,
      op_update   = 2'd2
   } req_opcode_e;

   // APB write action, taken from paddr[11:10]
   typedef enum logic [1:0] {
      maint_write  = 2'd0,
      maint_recall = 2'd1,
      maint_rsvd_2 = 2'd2,
      maint_rsvd_3 = 2'd3
   } maint_action_e;

   // One way; field order gives the APB layout nru:24, state:23:22, tag:21:0
   typedef struct packed {
      logic                 nru;
      cache_state_e         state;
      logic [TAG_W-1:0]     tag;
   } tag_entry_t;

   typedef struct packed {
      logic [ADDRESS_W-1:0] address;
      logic                 security;
      req_opcode_e          opcode;
      cache_state_e         new_state;
   } tag_req_t;

   // Whole set as held in the array
   typedef struct packed {
      tag_entry_t [N_WAYS-1:0] way;
   } tag_set_t;

   typedef struct packed {
      logic                 hit;
      logic [WAY_W-1:0]     way;
      cache_state_e         old_state;
      logic                 security;
      logic                 evict_valid;
      logic [TAG_W-1:0]     evict_tag;
      cache_state_e         evict_state;
   } tag_rsp_t;

endpackage

`default_nettype wire

//--- verilog/ccp_tag_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag, state and NRU storage for every set and way.
// Registered read port, whole-set write port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module ccp_tag_array (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       rd_en,
   input  logic [ccp_pkg::SET_W-1:0]  rd_set,
   output ccp_pkg::tag_set_t          rd_data,
   input  logic                       wr_en,
   input  logic [ccp_pkg::SET_W-1:0]  wr_set,
   input  ccp_pkg::tag_set_t          wr_data
);
   import ccp_pkg::*;

   tag_set_t mem [N_SETS];

   // All ways come up invalid with nru clear
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         for (int s = 0; s < N_SETS; s++) begin
            mem[s] <= '0;
         end
      end else if (wr_en) begin
         mem[wr_set] <= wr_data;
      end
   end

   // A write on the same edge is not seen here, the lookup stage forwards it
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_set];
      end
   end

endmodule

`default_nettype wire

//--- verilog/ccp_tag_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag pipeline top: index stage, tag array, lookup stage and
// APB maintenance, with the array ports shared between them.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module ccp_tag_pipe (
   input  logic               clk,
   input  logic               reset_n,
   input  logic               req_valid,
   output logic               req_ready,
   input  ccp_pkg::tag_req_t  req,
   output logic               rsp_valid,
   output ccp_pkg::tag_rsp_t  rsp,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [11:0]        paddr,
   input  logic [31:0]        pwdata,
   output logic [31:0]        prdata,
   output logic               pready,
   output logic               pslverr
);
   import ccp_pkg::*;

   logic              maint_busy;
   logic              pipe_empty;
   logic              maint_owns;
   logic              ix_rd_en;
   logic [SET_W-1:0]  ix_rd_set;
   logic              p1_valid;
   tag_req_t          p1_req;
   logic [TAG_W-1:0]  p1_tag;
   logic [SET_W-1:0]  p1_set;
   logic              lk_wr_en;
   logic [SET_W-1:0]  lk_wr_set;
   tag_set_t          lk_wr_data;
   logic              mt_rd_en;
   logic [SET_W-1:0]  mt_rd_set;
   logic              mt_wr_en;
   logic [SET_W-1:0]  mt_wr_set;
   tag_set_t          mt_wr_data;
   logic              rd_en;
   logic [SET_W-1:0]  rd_set;
   tag_set_t          rd_data;
   logic              wr_en;
   logic [SET_W-1:0]  wr_set;
   tag_set_t          wr_data;

   ccp_index_stage i_ccp_index_stage (
      .clk        (clk),
      .reset_n    (reset_n),
      .req_valid  (req_valid),
      .req        (req),
      .maint_busy (maint_busy),
      .req_ready  (req_ready),
      .rd_en      (ix_rd_en),
      .rd_set     (ix_rd_set),
      .p1_valid   (p1_valid),
      .p1_req     (p1_req),
      .p1_tag     (p1_tag),
      .p1_set     (p1_set)
   );

   // Maintenance gets the array only once the pipeline has drained
   assign maint_owns = maint_busy && pipe_empty;
   assign rd_en      = maint_owns ? mt_rd_en   : ix_rd_en;
   assign rd_set     = maint_owns ? mt_rd_set  : ix_rd_set;
   assign wr_en      = maint_owns ? mt_wr_en   : lk_wr_en;
   assign wr_set     = maint_owns ? mt_wr_set  : lk_wr_set;
   assign wr_data    = maint_owns ? mt_wr_data : lk_wr_data;

   ccp_tag_array i_ccp_tag_array (
      .clk     (clk),
      .reset_n (reset_n),
      .rd_en   (rd_en),
      .rd_set  (rd_set),
      .rd_data (rd_data),
      .wr_en   (wr_en),
      .wr_set  (wr_set),
      .wr_data (wr_data)
   );

   ccp_lookup_stage i_ccp_lookup_stage (
      .clk        (clk),
      .reset_n    (reset_n),
      .p1_valid   (p1_valid),
      .p1_req     (p1_req),
      .p1_tag     (p1_tag),
      .p1_set     (p1_set),
      .rd_data    (rd_data),
      .wr_en      (lk_wr_en),
      .wr_set     (lk_wr_set),
      .wr_data    (lk_wr_data),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .pipe_empty (pipe_empty)
   );

   ccp_maint_apb i_ccp_maint_apb (
      .clk        (clk),
      .reset_n    (reset_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .pipe_empty (pipe_empty),
      .maint_busy (maint_busy),
      .rd_en      (mt_rd_en),
      .rd_set     (mt_rd_set),
      .rd_data    (rd_data),
      .wr_en      (mt_wr_en),
      .wr_set     (mt_wr_set),
      .wr_data    (mt_wr_data)
   );

   // Pipeline writeback and maintenance never collide on the array
   single_array_writer: assert property (
      @(posedge clk) disable iff (!reset_n)
      !(lk_wr_en && mt_wr_en)
   );

endmodule

`default_nettype wire
